//--- cmpt_buffer/cmpt_fifo.sv
// DEPTH must be a power of two; read data is valid the cycle after the write (first word fall through)
`timescale 1ns/1ps

module cmpt_fifo
  import cmpt_pkg::*;
#(
  parameter int DEPTH           = 16,
  parameter int PROG_FULL_LEVEL = 12
) (
  input  logic       user_clk,
  input  logic       user_reset_n,
  input  cmpt_data_t wr_data,
  input  cmpt_meta_t wr_meta,
  input  logic       wr_last,
  input  logic       wr_valid,
  output logic       wr_ready,
  output cmpt_data_t rd_data,
  output cmpt_meta_t rd_meta,
  output logic       rd_last,
  output logic       rd_valid,
  input  logic       rd_ready,
  output logic       almost_empty,  // One or no entries held
  output logic       prog_full      // Occupancy at or above PROG_FULL_LEVEL
);

  localparam int             AW       = $clog2(DEPTH);
  localparam logic [AW:0]    FULL_CNT = (AW+1)'(DEPTH);
  localparam logic [AW:0]    PF_CNT   = (AW+1)'(PROG_FULL_LEVEL);

  // One storage word holds the beat and its sideband
  typedef struct packed {
    logic       last;
    cmpt_meta_t meta;
    cmpt_data_t data;
  } fifo_word_t;

  fifo_word_t        mem [DEPTH];
  fifo_word_t        wr_word;
  fifo_word_t        rd_word;
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;      // One extra bit so full and empty differ
  logic              wr_en;
  logic              rd_en;

  assign wr_ready = (count != FULL_CNT);
  assign rd_valid = (count != '0);
  assign wr_en    = wr_valid & wr_ready;
  assign rd_en    = rd_valid & rd_ready;

  assign wr_word.last = wr_last;
  assign wr_word.meta = wr_meta;
  assign wr_word.data = wr_data;

  always_ff @(posedge user_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Head of the queue is always on the read port
  assign rd_word = mem[rd_ptr];
  assign rd_data = rd_word.data;
  assign rd_meta = rd_word.meta;
  assign rd_last = rd_word.last;

  ///////////////////////////////
  // Pointers and occupancy
  ///////////////////////////////

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps since DEPTH is a power of two
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;            // Simultaneous push and pop keep the level
      endcase
    end
  end

  assign almost_empty = (count <= (AW+1)'(1));
  assign prog_full    = (count >= PF_CNT);

  // Full queue with no pop must not move its write pointer
  a_no_write_full: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    (count == FULL_CNT) && !rd_en |=> $stable(wr_ptr));

  // Empty queue must not move its read pointer
  a_no_read_empty: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    (count == '0) |=> $stable(rd_ptr));

endmodule

//--- cmpt_buffer/cmpt_release_ctrl.sv
// Burst gating is combinational on the FIFO read side; IDLE_LIMIT sets the timeout in clock cycles
`timescale 1ns/1ps

module cmpt_release_ctrl
  import cmpt_pkg::*;
#(
  parameter int IDLE_LIMIT = 4095
) (
  input  logic                   user_clk,
  input  logic                   user_reset_n,
  input  logic                   wr_fire,           // Entry written into the FIFO
  input  cmpt_data_t             rd_data,
  input  cmpt_meta_t             rd_meta,
  input  logic                   rd_last,
  input  logic                   rd_valid,
  input  logic                   almost_empty,
  input  logic                   prog_full,
  input  logic                   c2h_fifo_is_full,  // Payload side cannot take more data
  input  cmpt_knob_t             knob,
  input  logic                   cmpt_tready,
  output logic                   rd_ready,
  output cmpt_data_t             cmpt_tdata,
  output cmpt_meta_t             cmpt_meta,
  output logic [CMPT_DW_CNT-1:0] cmpt_dpar,
  output logic                   cmpt_tvalid,
  output logic                   cmpt_tlast
);

  localparam int              CW      = $clog2(IDLE_LIMIT + 1);
  localparam logic [CW-1:0]   IDLE_MAX = CW'(IDLE_LIMIT);

  logic [CW-1:0] idle_cnt;      // Cycles since the last FIFO write
  logic          idle_timeout;  // Buffered entries have gone stale
  logic          burst_start;
  logic          active;        // Burst in progress, runs until almost empty
  logic          release_open;  // Output path is allowed to move

  ///////////////////////////////
  // Idle timer
  ///////////////////////////////

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      idle_cnt <= '0;
    end else if (wr_fire) begin
      idle_cnt <= '0;                 // New traffic restarts the wait
    end else if (idle_cnt != IDLE_MAX) begin
      idle_cnt <= idle_cnt + 1'b1;    // Saturates at the limit
    end
  end

  assign idle_timeout = (idle_cnt == IDLE_MAX);

  ///////////////////////////////
  // Burst control
  ///////////////////////////////

  // Trade latency for long bursts, so wait until there is a reason to drain
  assign burst_start = knob.force_start |
                       (~almost_empty & (idle_timeout | c2h_fifo_is_full | prog_full));

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      active <= 1'b0;
    end else if (almost_empty) begin
      active <= 1'b0;                 // Burst ends with the last entry or two
    end else if (cmpt_tvalid) begin
      active <= 1'b1;
    end
  end

  assign release_open = (burst_start | active) & ~knob.hold;
  assign cmpt_tvalid  = release_open & rd_valid;
  assign rd_ready     = release_open & cmpt_tready;  // Pop only on an accepted beat

  assign cmpt_tdata = rd_data;
  assign cmpt_meta  = rd_meta;
  assign cmpt_tlast = rd_last;

  // Inverted parity over each 32-bit word of the outgoing data
  for (genvar w = 0; w < CMPT_DW_CNT; w++) begin : g_dpar
    assign cmpt_dpar[w] = ~(^cmpt_tdata[32*w +: 32]);
  end

  // Hold keeps the head of the FIFO in place, so no buffered entry leaves while it is set
  a_hold_blocks: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    knob.hold && rd_valid |=> rd_valid && $stable(rd_meta));

endmodule

//--- common/cmpt_pkg.sv
// Shared widths and types for the completion path; entry width is fixed at 512 bits, 16 words of 32
package cmpt_pkg;

  ///////////////////////////////
  // Widths
  ///////////////////////////////

  localparam int CMPT_DATA_W = 512;                // One completion entry per beat
  localparam int CMPT_DW_CNT = CMPT_DATA_W / 32;   // One parity bit per 32-bit word
  localparam int QID_W       = 11;                 // Queue ID width on the completion sideband
  localparam int LEN_W       = 16;                 // Largest packet length the stream can carry
  localparam int PKT_ID_W    = 16;                 // Packet ID counter width, wraps on overflow
  localparam int USER_DATA_W = 128;                // Custom write-back data copied into the entry

  ///////////////////////////////
  // Types
  ///////////////////////////////

  typedef logic [CMPT_DATA_W-1:0] cmpt_data_t;

  // Code 0 means 8 bytes, code 1 means 16 bytes and code 2 means 32 bytes
  typedef logic [1:0] cmpt_size_t;

  // Request fields that arrive together with the formed strobe
  typedef struct packed {
    logic                   marker;     // Payload packet is a marker packet
    logic [QID_W-1:0]       qid;        // Queue that owns the packet
    cmpt_size_t             size;       // Completion size code
    logic [LEN_W-1:0]       btt;        // Payload length in bytes, not the completion length
    logic [USER_DATA_W-1:0] user_data;  // Custom write-back bits
  } cmpt_req_t;

  // Sideband stored next to each entry in the buffer (30 bits)
  typedef struct packed {
    logic [PKT_ID_W-1:0] pkt_id;        // Payload packet this completion belongs to
    logic                marker;
    logic [QID_W-1:0]    qid;
    cmpt_size_t          size;
  } cmpt_meta_t;

  // Run-time control of the release logic
  typedef struct packed {
    logic force_start;                  // Release entries as soon as they are buffered
    logic hold;                         // Block the outgoing stream entirely
  } cmpt_knob_t;

  // Entry builder states
  typedef enum logic {
    BLD_IDLE,                           // No entry on offer
    BLD_OFFER                           // Entry on offer to the buffer
  } builder_state_e;

endpackage

//--- dv/cmpt_tb.sv
// Self-checking testbench; runs with IDLE_LIMIT at 63 so the stale-entry timeout fits a short run
`timescale 1ns/1ps

module cmpt_tb
  import cmpt_pkg::*;
();

  logic                   user_clk;
  logic                   user_reset_n;
  logic                   c2h_formed;
  cmpt_req_t              req;
  logic                   c2h_fifo_is_full;
  cmpt_knob_t             knob;
  logic                   cmpt_tready;
  logic                   cmpt_sent;
  logic                   wb_is_full;
  cmpt_data_t             cmpt_tdata;
  cmpt_meta_t             cmpt_meta;
  logic [CMPT_DW_CNT-1:0] cmpt_dpar;
  logic                   cmpt_tvalid;
  logic                   cmpt_tlast;

  integer              seed = 27740;
  int                  errors;
  int                  test_num;
  int                  test_base;       // Error count when the current test began
  int                  sent_cnt;        // cmpt_sent pulses since reset
  int                  recv_cnt;        // Entries accepted on the output stream
  logic [PKT_ID_W-1:0] next_pkt_id;     // Model of the packet counter
  cmpt_data_t          exp_data_q[$];
  cmpt_meta_t          exp_meta_q[$];
  cmpt_req_t           batch[40];
  bit                  sending_done;

  cmpt_wb_top #(.IDLE_LIMIT(63)) cmpt_wb_top_inst (.*);

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;    // 8 ns period
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Entry layout built field by field from the format table
  function automatic cmpt_data_t format_entry(cmpt_req_t r);
    cmpt_data_t d;
    d = '0;                             // Bits 2:0 stay zero
    d[3] = 1'b1;                        // Descriptor used
    d[19:4] = r.btt;
    d[127:20] = r.user_data[127:20];
    for (int c = 1; c < 4; c++) begin
      d[128*c +: 128] = r.user_data;    // Three full copies above bit 127
    end
    return d;
  endfunction

  function automatic logic [CMPT_DW_CNT-1:0] word_parity(cmpt_data_t d);
    logic [CMPT_DW_CNT-1:0] p;
    for (int w = 0; w < CMPT_DW_CNT; w++) begin
      p[w] = ~(^d[32*w +: 32]);         // Inverted XOR of each 32-bit word
    end
    return p;
  endfunction

  function automatic cmpt_req_t random_req();
    cmpt_req_t   r;
    logic [31:0] rnd [6];
    for (int k = 0; k < 6; k++) begin
      rnd[k] = $random(seed);
    end
    r.marker    = rnd[0][0];
    r.qid       = rnd[0][11:1];
    r.size      = cmpt_size_t'(rnd[0][31:12] % 3);  // Only codes 0 to 2 are defined
    r.btt       = rnd[1][15:0];
    r.user_data = {rnd[2], rnd[3], rnd[4], rnd[5]};
    return r;
  endfunction

  task automatic check_data(input string name, input cmpt_data_t got, input cmpt_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_meta(input string name, input cmpt_meta_t got, input cmpt_meta_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dpar(input string name, input logic [CMPT_DW_CNT-1:0] got,
                            input logic [CMPT_DW_CNT-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  // Outputs and strobes are settled at the falling edge; the transfer happens on the next rise
  always @(negedge user_clk) begin : monitor
    cmpt_meta_t m;
    cmpt_data_t exp_d;
    if (!user_reset_n) begin
      next_pkt_id = PKT_ID_W'(1);
    end else begin
      if (cmpt_sent) begin
        m.pkt_id = next_pkt_id;
        m.marker = req.marker;
        m.qid    = req.qid;
        m.size   = req.size;
        exp_data_q.push_back(format_entry(req));
        exp_meta_q.push_back(m);
        next_pkt_id++;                  // IDs wrap at 16 bits like the packet counter
        sent_cnt++;
      end
      if (cmpt_tvalid && cmpt_tready) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("entry with packet id %h left with no request outstanding", cmpt_meta.pkt_id);
        end else begin
          exp_d = exp_data_q.pop_front();
          check_data("cmpt_tdata", cmpt_tdata, exp_d);
          check_meta("cmpt_meta", cmpt_meta, exp_meta_q.pop_front());
          check_dpar("cmpt_dpar", cmpt_dpar, word_parity(exp_d));
        end
        check_bit("cmpt_tlast", cmpt_tlast, 1'b1);
        recv_cnt++;
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Holds the strobe until cmpt_sent, then returns one step after the accepting edge
  task automatic send_req(input cmpt_req_t r);
    int t;
    bit taken;
    c2h_formed = 1'b1;
    req        = r;
    t          = 0;
    taken      = 1'b0;
    while (!taken && t < 100) begin
      @(negedge user_clk);
      taken = cmpt_sent;
      @(posedge user_clk);
      #1;
      t++;
    end
    if (!taken) begin
      errors++;
      $display("request was not accepted within 100 cycles");
    end
  endtask

  task automatic send_batch(input int n);
    for (int i = 0; i < n; i++) begin
      batch[i] = random_req();          // Drawn up front so the seed order stays fixed
    end
    @(posedge user_clk);
    #1;
    for (int i = 0; i < n; i++) begin
      send_req(batch[i]);               // Back to back, no idle cycle between requests
    end
    c2h_formed = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int t;
    t = 0;
    do begin
      @(posedge user_clk);
      #1;
      t++;
    end while (recv_cnt != sent_cnt && t < limit);
    if (recv_cnt != sent_cnt) begin
      errors++;
      $display("timeout, %0d entries still missing after %0d cycles", sent_cnt - recv_cnt, t);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int t;
    bit seen;
    t    = 0;
    seen = 1'b0;
    while (!seen && t < cycles) begin
      @(negedge user_clk);
      seen = cmpt_tvalid;
      t++;
    end
    if (seen) begin
      errors++;
      $display("output became valid after %0d cycles while it had to stay idle", t);
    end
    @(posedge user_clk);
    #1;
  endtask

  // A burst started by the fill level must show wb_is_full when it opens
  task automatic wait_burst_start(input int limit);
    int t;
    bit seen;
    t    = 0;
    seen = 1'b0;
    while (!seen && t < limit) begin
      @(negedge user_clk);
      seen = cmpt_tvalid;
      t++;
    end
    if (seen) begin
      check_bit("wb_is_full", wb_is_full, 1'b1);
    end else begin
      errors++;
      $display("output did not start within %0d cycles of the fill level", limit);
    end
    @(posedge user_clk);
    #1;
  endtask

  task automatic random_ready();
    logic [31:0] rnd;
    while (!sending_done) begin
      @(posedge user_clk);
      #1;
      rnd = $random(seed);
      cmpt_tready = rnd[0];
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int base;
    user_reset_n     = 1'b0;
    c2h_formed       = 1'b0;
    req              = '0;
    c2h_fifo_is_full = 1'b0;
    knob             = '0;
    cmpt_tready      = 1'b1;
    errors           = 0;
    test_num         = 0;
    test_base        = 0;
    sent_cnt         = 0;
    recv_cnt         = 0;
    next_pkt_id      = PKT_ID_W'(1);
    sending_done     = 1'b0;
    repeat (3) @(posedge user_clk);
    #1;
    user_reset_n = 1'b1;

    knob.force_start = 1'b1;            // Every entry leaves as soon as it is buffered
    send_batch(20);
    wait_drain(100);
    end_test("entry format");
    send_batch(10);
    wait_drain(100);
    end_test("packet id and sideband");
    send_batch(10);
    wait_drain(100);
    end_test("parity");

    knob.hold = 1'b1;                   // Hold wins over force_start
    send_batch(8);
    expect_quiet(100);
    knob.hold = 1'b0;
    wait_drain(100);
    end_test("hold");

    // A lone entry counts as almost empty, so the timeout case uses two
    knob = '0;
    send_batch(2);
    expect_quiet(32);
    wait_drain(200);
    send_batch(12);
    wait_burst_start(20);               // Well inside the 63-cycle timeout
    wait_drain(100);
    send_batch(3);
    expect_quiet(10);
    c2h_fifo_is_full = 1'b1;
    wait_drain(20);
    c2h_fifo_is_full = 1'b0;
    end_test("release rules");

    base = sent_cnt;
    fork
      begin
        send_batch(40);
        sending_done = 1'b1;
      end
      random_ready();
    join
    cmpt_tready      = 1'b1;
    knob.force_start = 1'b1;            // Flushes a last entry that no burst would release
    wait_drain(200);
    if (sent_cnt - base != 40) begin
      errors++;
      $display("only %0d of 40 requests were accepted", sent_cnt - base);
    end
    end_test("back-pressure");

    $display("tests %0d, sent %0d, received %0d, errors %0d", test_num, sent_cnt, recv_cnt,
             errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- hw/cmpt_entry_builder.sv
// Sender must hold c2h_formed until cmpt_sent; requests during a stalled offer are ignored
`timescale 1ns/1ps

module cmpt_entry_builder
  import cmpt_pkg::*;
(
  input  logic           user_clk,
  input  logic           user_reset_n,
  input  logic           c2h_formed,    // Payload packet is formed, build its completion
  input  cmpt_req_t      req,           // Request fields, valid with c2h_formed
  input  logic           entry_ready,   // Buffer can take the entry on offer
  output cmpt_data_t     entry_data,
  output cmpt_meta_t     entry_meta,
  output logic           entry_valid,
  output logic           entry_last,
  output logic           cmpt_sent      // Request accepted in this cycle
);

  builder_state_e      state;
  logic                accept;          // Request taken this cycle
  logic                wr_fire;         // Entry handed to the buffer this cycle
  logic [PKT_ID_W-1:0] pkt_cnt;         // ID of the next entry written to the buffer
  logic                marker_q;
  logic [QID_W-1:0]    qid_q;
  cmpt_size_t          size_q;

  // A new request may replace the offered entry only in the cycle the buffer takes it
  assign accept      = c2h_formed & ((state == BLD_IDLE) | entry_ready);
  assign cmpt_sent   = accept;
  assign entry_valid = (state == BLD_OFFER);
  assign entry_last  = 1'b1;            // Every completion is a single beat
  assign wr_fire     = entry_valid & entry_ready;

  ///////////////////////////////
  // Offer state machine
  ///////////////////////////////

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      state <= BLD_IDLE;
    end else begin
      case (state)
        BLD_IDLE: begin
          if (accept) begin
            state <= BLD_OFFER;
          end
        end
        BLD_OFFER: begin
          if (wr_fire && !accept) begin  // Buffer took it and nothing new is waiting
            state <= BLD_IDLE;
          end
        end
        default: begin
          state <= BLD_IDLE;
        end
      endcase
    end
  end

  // Entry layout follows the standard completion format the host driver parses
  // Bits 2:0 reserved, bit 3 marks the descriptor as used, bits 19:4 carry the length
  always_ff @(posedge user_clk) begin
    if (accept) begin
      entry_data <= {{3{req.user_data}}, req.user_data[USER_DATA_W-1:20], req.btt, 1'b1, 3'b000};
      marker_q   <= req.marker;
      qid_q      <= req.qid;
      size_q     <= req.size;
    end
  end

  // Packet IDs start at 1 and must match the payload packet numbering
  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      pkt_cnt <= PKT_ID_W'(1);
    end else if (wr_fire) begin
      pkt_cnt <= pkt_cnt + 1'b1;         // Wraps at 16 bits
    end
  end

  always_comb begin
    entry_meta.pkt_id = pkt_cnt;         // Tagged at the buffer input, not at acceptance
    entry_meta.marker = marker_q;
    entry_meta.qid    = qid_q;
    entry_meta.size   = size_q;
  end

  // A stalled offer keeps its entry until the buffer takes it
  a_stall_stable: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    entry_valid && !entry_ready |=> entry_valid && $stable(entry_data));

endmodule

//--- hw/cmpt_wb_top.sv
// Completion write-back path; constant control fields of the stream are tied by the consumer
`timescale 1ns/1ps

module cmpt_wb_top
  import cmpt_pkg::*;
#(
  parameter int FIFO_DEPTH      = 16,    // Power of two
  parameter int PROG_FULL_LEVEL = 12,    // Level that raises wb_is_full
  parameter int IDLE_LIMIT      = 4095   // Idle cycles before stale entries are released
) (
  input  logic                   user_clk,
  input  logic                   user_reset_n,
  input  logic                   c2h_formed,
  input  cmpt_req_t              req,
  input  logic                   c2h_fifo_is_full,
  input  cmpt_knob_t             knob,
  input  logic                   cmpt_tready,
  output logic                   cmpt_sent,
  output logic                   wb_is_full,
  output cmpt_data_t             cmpt_tdata,
  output cmpt_meta_t             cmpt_meta,
  output logic [CMPT_DW_CNT-1:0] cmpt_dpar,
  output logic                   cmpt_tvalid,
  output logic                   cmpt_tlast
);

  ///////////////////////////////
  // Internal streams
  ///////////////////////////////

  cmpt_data_t entry_data;     // Builder to FIFO
  cmpt_meta_t entry_meta;
  logic       entry_valid;
  logic       entry_last;
  logic       entry_ready;
  logic       wr_fire;        // Write into the FIFO this cycle
  cmpt_data_t rd_data;        // FIFO to release control
  cmpt_meta_t rd_meta;
  logic       rd_last;
  logic       rd_valid;
  logic       rd_ready;
  logic       almost_empty;
  logic       prog_full;

  assign wr_fire    = entry_valid & entry_ready;
  assign wb_is_full = prog_full;

  cmpt_entry_builder cmpt_entry_builder_inst (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .c2h_formed   (c2h_formed),
    .req          (req),
    .entry_ready  (entry_ready),
    .entry_data   (entry_data),
    .entry_meta   (entry_meta),
    .entry_valid  (entry_valid),
    .entry_last   (entry_last),
    .cmpt_sent    (cmpt_sent)
  );

  cmpt_fifo #(
    .DEPTH           (FIFO_DEPTH),
    .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
  ) cmpt_fifo_inst (
    .user_clk     (user_clk),
    .user_reset_n (user_reset_n),
    .wr_data      (entry_data),
    .wr_meta      (entry_meta),
    .wr_last      (entry_last),
    .wr_valid     (entry_valid),
    .wr_ready     (entry_ready),
    .rd_data      (rd_data),
    .rd_meta      (rd_meta),
    .rd_last      (rd_last),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .almost_empty (almost_empty),
    .prog_full    (prog_full)
  );

  cmpt_release_ctrl #(
    .IDLE_LIMIT (IDLE_LIMIT)
  ) cmpt_release_ctrl_inst (
    .user_clk         (user_clk),
    .user_reset_n     (user_reset_n),
    .wr_fire          (wr_fire),
    .rd_data          (rd_data),
    .rd_meta          (rd_meta),
    .rd_last          (rd_last),
    .rd_valid         (rd_valid),
    .almost_empty     (almost_empty),
    .prog_full        (prog_full),
    .c2h_fifo_is_full (c2h_fifo_is_full),
    .knob             (knob),
    .cmpt_tready      (cmpt_tready),
    .rd_ready         (rd_ready),
    .cmpt_tdata       (cmpt_tdata),
    .cmpt_meta        (cmpt_meta),
    .cmpt_dpar        (cmpt_dpar),
    .cmpt_tvalid      (cmpt_tvalid),
    .cmpt_tlast       (cmpt_tlast)
  );

endmodule

//--- list.f
common/cmpt_pkg.sv
hw/cmpt_entry_builder.sv
cmpt_buffer/cmpt_fifo.sv
cmpt_buffer/cmpt_release_ctrl.sv
hw/cmpt_wb_top.sv
dv/cmpt_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cmpt_tb -f list.f -o cmpt_sim
out=$(./obj_dir/cmpt_sim)
echo "$out"
if echo "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1
